// File: sources.f
source/sens_regs_pkg.sv
source/sens_data_pkg.sv
source/pkword_if.sv
source/cmd_deser.sv
source/px_packer.sv
source/line_buf.sv
source/sens_chan_ctrl.sv
source/status_router.sv
source/sensor_subsys.sv
test/tb_sensor_subsys.sv

// File: test/tb_sensor_subsys.sv
// testbench for sensor_subsys: stimulus tasks, packing and line count model, assertions, report
`timescale 1ns/100ps

module tb_sensor_subsys;

    localparam int NCH       = sens_regs_pkg::NUM_CHN;
    localparam int RESET_LEN = 10;    // cycles per test, rough upper bounds
    localparam int T16_LEN   = 40;
    localparam int T8_LEN    = 40;
    localparam int OVF_LEN   = 120;
    localparam int ROUTE_LEN = 120;
    localparam int LIMIT     = 2 * (RESET_LEN + T16_LEN + T8_LEN + OVF_LEN + ROUTE_LEN);

    logic           mclk;
    logic           arst_n;
    logic [7:0]     cmd_ad;
    logic           cmd_stb;
    logic [7:0]     status_ad;
    logic           status_rq;
    logic           status_start;
    logic [15:0]    px_data [NCH];
    logic [NCH-1:0] px_valid;
    logic [NCH-1:0] px_last;
    logic [NCH-1:0] rpage_set;
    logic [NCH-1:0] rpage_next;
    logic [NCH-1:0] buf_rd;
    logic [63:0]    buf_dout [NCH];

    int             errors;
    int             checks;
    int             cycles;
    logic [15:0]    lfsr;             // galois state
    logic [63:0]    line_words [$];   // expected words of the last line
    logic [15:0]    exp_lines [NCH];  // model of kept lines
    int             exp_fill [NCH];   // model of filled pages
    logic           exp_ovf [NCH];
    logic           exp_en [NCH];

    sensor_subsys i_sensor_subsys (
        .mclk         (mclk),
        .arst_n       (arst_n),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start),
        .px_data      (px_data),
        .px_valid     (px_valid),
        .px_last      (px_last),
        .rpage_set    (rpage_set),
        .rpage_next   (rpage_next),
        .buf_rd       (buf_rd),
        .buf_dout     (buf_dout)
    );

    always #10 mclk = ~mclk;          // 20 ns period

    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout, run exceeded %0d cycles", LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // request must drop once the receiver took the address byte
    assert property (@(posedge mclk) disable iff (!arst_n) status_start |=> !status_rq)
        else begin
            errors++;
            $display("status_rq still high the cycle after status_start at %0t", $time);
        end

    for (genvar c = 0; c < NCH; c++) begin : g_hold
        assert property (@(posedge mclk) disable iff (!arst_n) !buf_rd[c] |=> $stable(buf_dout[c]))
            else begin
                errors++;
                $display("buf_dout[%0d] changed without buf_rd at %0t", c, $time);
            end
    end

    task tick;
        @(posedge mclk);
        #2;                           // drive point after the edge
    endtask

    task check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    function logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000); // x^16+x^14+x^13+x^11+1
        return b;
    endfunction

    function logic [15:0] rand_sample();
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < 16; k++) begin
            v = {v[14:0], lfsr_bit()};  // one step per bit
        end
        return v;
    endfunction

    function logic [15:0] chan_addr(input int ch, input int raddr);
        return 16'(sens_regs_pkg::SENSOR_GROUP_ADDR + sens_regs_pkg::SENSOR_BASE_INC * ch + raddr);
    endfunction

    task send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr};         // AL first
        for (int k = 0; k < sens_regs_pkg::CMD_BYTES; k++) begin
            cmd_ad  = bytes[k*8 +: 8];
            cmd_stb = (k == 0);
            tick;
        end
        cmd_stb = 1'b0;
        repeat (3) tick;              // write lands 7 cycles after strobe
    endtask

    task set_mode(input int ch, input logic en, input logic m16);
        logic [31:0] d;
        d = '0;
        d[sens_regs_pkg::MODE_EN_BIT]    = en;
        d[sens_regs_pkg::MODE_16BIT_BIT] = m16;
        exp_en[ch] = en;
        send_cmd(chan_addr(ch, sens_regs_pkg::MODE_RADDR), d);
    endtask

    task automatic send_line(input int ch, input int n, input logic m16);
        logic [15:0] s [$];
        logic [15:0] v;
        logic [63:0] w;
        int          lanes;
        line_words.delete();
        for (int k = 0; k < n; k++) begin
            s.push_back(rand_sample());
            px_data[ch]  = s[k];
            px_valid[ch] = 1'b1;
            px_last[ch]  = (k == n - 1);
            tick;
        end
        px_valid[ch] = 1'b0;
        px_last[ch]  = 1'b0;
        lanes = m16 ? 4 : 8;
        for (int i = 0; i < n; i += lanes) begin
            w = '0;                   // unfilled lanes stay zero
            for (int l = 0; l < lanes && i + l < n; l++) begin
                v = s[i+l];
                if (m16) begin
                    w[l*16 +: 16] = v;
                end else begin
                    w[l*8 +: 8] = v[15:8];  // upper byte only
                end
            end
            line_words.push_back(w);
        end
        if (exp_en[ch]) begin
            if (exp_fill[ch] < sens_data_pkg::NUM_PAGES) begin
                exp_fill[ch]++;
                exp_lines[ch]++;
            end else begin
                exp_ovf[ch] = 1'b1;   // no free page
            end
        end
        repeat (3) tick;              // line_end, then keep decision
    endtask

    task read_words(input int ch, input int n);
        for (int k = 0; k < n; k++) begin
            buf_rd[ch] = 1'b1;
            tick;                     // data one cycle after buf_rd
            check_val($sformatf("buf_dout[%0d]", ch), line_words[k], buf_dout[ch]);
        end
        buf_rd[ch] = 1'b0;
    endtask

    task release_page(input int ch);
        rpage_next[ch] = 1'b1;
        tick;
        rpage_next[ch] = 1'b0;
        if (exp_fill[ch] > 0) begin
            exp_fill[ch]--;
        end
    endtask

    task request_status(input int ch, input logic [5:0] seq);
        send_cmd(chan_addr(ch, sens_regs_pkg::STATUS_RQ_RADDR), {26'b0, seq});
    endtask

    task get_packet(output logic [31:0] pkt);
        while (!status_rq) begin
            tick;
        end
        status_start = 1'b1;          // take address byte
        pkt[7:0]     = status_ad;
        tick;
        status_start = 1'b0;
        pkt[15:8]    = status_ad;
        tick;
        pkt[23:16]   = status_ad;
        tick;
        pkt[31:24]   = status_ad;
    endtask

    task check_packet(input int ch, input logic [31:0] pkt, input logic [5:0] seq);
        check_val("status_ad addr", 8'(sens_regs_pkg::STATUS_REG_BASE
                  + sens_regs_pkg::STATUS_REG_INC * ch), pkt[7:0]);
        check_val("status_ad lines lo", exp_lines[ch][7:0], pkt[15:8]);
        check_val("status_ad lines hi", exp_lines[ch][15:8], pkt[23:16]);
        check_val("status_ad flags", {exp_ovf[ch], exp_en[ch], seq}, pkt[31:24]);
    endtask

    task end_test(input string name, input int err0);
        $display("test %-8s %s, %0d errors", name, (errors == err0) ? "ok" : "FAILED",
                 errors - err0);
    endtask

    initial begin
        logic [31:0] pkt;
        logic [63:0] saved;
        logic [NCH-1:0] seen;
        int err0;
        int ch;
        mclk = 1'b0;
        arst_n = 1'b0;
        cmd_ad = '0;
        cmd_stb = 1'b0;
        status_start = 1'b0;
        px_valid = '0;
        px_last = '0;
        rpage_set = '0;
        rpage_next = '0;
        buf_rd = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        lfsr = 16'd14;                // seed
        for (int c = 0; c < NCH; c++) begin
            px_data[c] = '0;
            exp_lines[c] = '0;
            exp_fill[c] = 0;
            exp_ovf[c] = 1'b0;
            exp_en[c] = 1'b0;
        end
        repeat (3) @(posedge mclk);
        #2;
        arst_n = 1'b1;
        tick;

        err0 = errors;
        check_val("status_rq", 0, status_rq);
        for (int c = 0; c < NCH; c++) begin
            check_val($sformatf("buf_dout[%0d]", c), '0, buf_dout[c]);
        end
        end_test("reset", err0);

        err0 = errors;
        set_mode(0, 1'b1, 1'b1);
        send_line(0, 10, 1'b1);       // 3 words, last half full
        read_words(0, 3);
        end_test("line16", err0);

        err0 = errors;
        set_mode(2, 1'b1, 1'b0);
        send_line(2, 12, 1'b0);
        read_words(2, 2);
        end_test("line8", err0);

        err0 = errors;
        set_mode(1, 1'b1, 1'b1);
        for (int k = 0; k < 5; k++) begin
            send_line(1, 4, 1'b1);    // fifth line has no page
            if (k == 1) begin
                saved = line_words[0];
            end
        end
        request_status(1, 6'h05);
        get_packet(pkt);
        check_packet(1, pkt, 6'h05);
        release_page(1);              // page 0 freed, reads move to page 1
        line_words.delete();
        line_words.push_back(saved);
        read_words(1, 1);
        send_line(1, 4, 1'b1);
        request_status(1, 6'h06);
        get_packet(pkt);
        check_packet(1, pkt, 6'h06);
        end_test("overflow", err0);

        err0 = errors;
        send_line(3, 8, 1'b0);        // channel 3 never enabled
        for (int c = 0; c < NCH; c++) begin
            request_status(c, 6'(6'h10 + c));
        end
        seen = '0;
        for (int k = 0; k < NCH; k++) begin
            get_packet(pkt);
            ch = (int'(pkt[7:0]) - sens_regs_pkg::STATUS_REG_BASE) / sens_regs_pkg::STATUS_REG_INC;
            if (pkt[0] || ch < 0 || ch >= NCH || seen[ch]) begin
                errors++;
                $display("unexpected or repeated status address byte %h at %0t", pkt[7:0], $time);
            end else begin
                seen[ch] = 1'b1;
                check_packet(ch, pkt, 6'(6'h10 + ch));
            end
        end
        end_test("routing", err0);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: source/sensor_subsys.sv
// top level, command receiver, four channel slices and status router
`timescale 1ns/100ps

module sensor_subsys (
    input  logic                              mclk,
    input  logic                              arst_n,
    input  logic [7:0]                        cmd_ad,
    input  logic                              cmd_stb,
    output logic [7:0]                        status_ad,
    output logic                              status_rq,
    input  logic                              status_start,
    input  logic [15:0]                       px_data [sens_regs_pkg::NUM_CHN],
    input  logic [sens_regs_pkg::NUM_CHN-1:0] px_valid,
    input  logic [sens_regs_pkg::NUM_CHN-1:0] px_last,
    input  logic [sens_regs_pkg::NUM_CHN-1:0] rpage_set,
    input  logic [sens_regs_pkg::NUM_CHN-1:0] rpage_next,
    input  logic [sens_regs_pkg::NUM_CHN-1:0] buf_rd,
    output logic [63:0]                       buf_dout [sens_regs_pkg::NUM_CHN]
);

    logic [15:0]                       cmd_addr;  // to all channels
    logic [31:0]                       cmd_data;
    logic                              cmd_wr;
    logic [7:0]                        st_ad [sens_regs_pkg::NUM_CHN];
    logic [sens_regs_pkg::NUM_CHN-1:0] st_rq;
    logic [sens_regs_pkg::NUM_CHN-1:0] st_start;

    cmd_deser i_cmd_deser (
        .mclk     (mclk),
        .arst_n   (arst_n),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd_wr   (cmd_wr)
    );

    for (genvar i = 0; i < sens_regs_pkg::NUM_CHN; i++) begin : g_chn
        logic                     en;
        logic                     mode16;
        sens_data_pkg::line_cnt_t lines;
        logic                     overflow;
        pkword_if                 pk ();         // packer to buffer

        px_packer i_px_packer (
            .mclk     (mclk),
            .arst_n   (arst_n),
            .px_data  (px_data[i]),
            .px_valid (px_valid[i]),
            .px_last  (px_last[i]),
            .en       (en),
            .mode16   (mode16),
            .pk       (pk.src)
        );

        line_buf i_line_buf (
            .mclk       (mclk),
            .arst_n     (arst_n),
            .pk         (pk.dst),
            .rpage_set  (rpage_set[i]),
            .rpage_next (rpage_next[i]),
            .buf_rd     (buf_rd[i]),
            .buf_dout   (buf_dout[i]),
            .lines      (lines),
            .overflow   (overflow)
        );

        sens_chan_ctrl i_sens_chan_ctrl (
            .mclk     (mclk),
            .arst_n   (arst_n),
            .chn      (sens_regs_pkg::CHN_W'(i)), // selects address window
            .cmd_addr (cmd_addr),
            .cmd_data (cmd_data),
            .cmd_wr   (cmd_wr),
            .lines    (lines),
            .overflow (overflow),
            .st_start (st_start[i]),
            .en       (en),
            .mode16   (mode16),
            .st_ad    (st_ad[i]),
            .st_rq    (st_rq[i])
        );
    end

    status_router i_status_router (
        .mclk         (mclk),
        .arst_n       (arst_n),
        .st_ad        (st_ad),
        .st_rq        (st_rq),
        .status_start (status_start),
        .st_start     (st_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq)
    );

endmodule

// File: source/status_router.sv
// round-robin merge of channel status packets into one byte stream
`timescale 1ns/100ps

module status_router (
    input  logic                              mclk,
    input  logic                              arst_n,
    input  logic [7:0]                        st_ad [sens_regs_pkg::NUM_CHN],
    input  logic [sens_regs_pkg::NUM_CHN-1:0] st_rq,
    input  logic                              status_start,
    output logic [sens_regs_pkg::NUM_CHN-1:0] st_start,
    output logic [7:0]                        status_ad,
    output logic                              status_rq
);

    logic [sens_regs_pkg::CHN_W-1:0] g;        // granted, also rr pointer
    logic [sens_regs_pkg::CHN_W-1:0] pick;
    logic [sens_regs_pkg::CHN_W-1:0] idx;
    logic                            found;
    logic                            busy;     // grant held
    logic                            sending;  // bytes after start
    logic [1:0]                      cnt;      // bytes still to pass
    logic                            start_ok;

    always_comb begin
        pick  = g;
        found = 1'b0;
        for (int i = 1; i <= sens_regs_pkg::NUM_CHN; i++) begin
            idx = g + sens_regs_pkg::CHN_W'(i);  // start after last grant
            if (!found && st_rq[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            g       <= '0;
            busy    <= 1'b0;
            sending <= 1'b0;
            cnt     <= '0;
        end else if (!busy) begin
            if (found) begin
                busy <= 1'b1;
                g    <= pick;
            end
        end else if (!sending) begin
            if (status_start) begin
                sending <= 1'b1;
                cnt     <= 2'(sens_regs_pkg::STATUS_BYTES - 1);
            end
        end else begin
            cnt <= cnt - 2'd1;
            if (cnt == 2'd1) begin
                busy    <= 1'b0;             // last byte out this cycle
                sending <= 1'b0;
            end
        end
    end

    assign start_ok  = busy && !sending && status_start;
    assign st_start  = {{(sens_regs_pkg::NUM_CHN-1){1'b0}}, start_ok} << g; // granted only
    assign status_rq = busy && !sending && st_rq[g];
    assign status_ad = st_ad[g];

endmodule

// File: source/sens_chan_ctrl.sv
// channel mode register and status packet sender
`timescale 1ns/100ps

module sens_chan_ctrl (
    input  logic                            mclk,
    input  logic                            arst_n,
    input  logic [sens_regs_pkg::CHN_W-1:0] chn,      // tied to channel index
    input  logic [15:0]                     cmd_addr,
    input  logic [31:0]                     cmd_data,
    input  logic                            cmd_wr,
    input  sens_data_pkg::line_cnt_t        lines,
    input  logic                            overflow,
    input  logic                            st_start, // address byte taken
    output logic                            en,
    output logic                            mode16,
    output logic [7:0]                      st_ad,
    output logic                            st_rq
);

    logic [15:0]              base;      // channel register base
    logic [7:0]               st_addr;   // first packet byte
    logic                     wr_mode;
    logic                     wr_stat;
    logic [1:0]               idx;       // packet byte, 0 = address
    logic [5:0]               seq;
    sens_data_pkg::line_cnt_t lines_snap;
    logic                     ovf_snap;

    assign base    = 16'(sens_regs_pkg::SENSOR_GROUP_ADDR + sens_regs_pkg::SENSOR_BASE_INC * chn);
    assign st_addr = 8'(sens_regs_pkg::STATUS_REG_BASE + sens_regs_pkg::STATUS_REG_INC * chn);
    assign wr_mode = cmd_wr && cmd_addr == base + 16'(sens_regs_pkg::MODE_RADDR);
    assign wr_stat = cmd_wr && cmd_addr == base + 16'(sens_regs_pkg::STATUS_RQ_RADDR);

    always_ff @(posedge mclk) begin
        if (wr_stat) begin
            seq        <= cmd_data[5:0];     // echoed back in last byte
            lines_snap <= lines;
            ovf_snap   <= overflow;
        end
    end

    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            en     <= 1'b0;
            mode16 <= 1'b0;
            st_rq  <= 1'b0;
            idx    <= '0;
        end else begin
            if (wr_mode) begin
                en     <= cmd_data[sens_regs_pkg::MODE_EN_BIT];
                mode16 <= cmd_data[sens_regs_pkg::MODE_16BIT_BIT];
            end
            if (wr_stat) begin
                st_rq <= 1'b1;               // hold until started
            end else if (st_start) begin
                st_rq <= 1'b0;
            end
            if (st_start) begin
                idx <= 2'd1;
            end else if (idx == sens_regs_pkg::STATUS_BYTES - 1) begin
                idx <= '0;                   // packet done
            end else if (idx != 0) begin
                idx <= idx + 2'd1;
            end
        end
    end

    always_comb begin
        case (idx)
            2'd0:    st_ad = st_addr;
            2'd1:    st_ad = lines_snap[7:0];
            2'd2:    st_ad = lines_snap[15:8];
            default: st_ad = {ovf_snap, en, seq};
        endcase
    end

endmodule

// File: source/line_buf.sv
// four page line buffer, keep or drop at line end, registered memory reads
`timescale 1ns/100ps

module line_buf (
    input  logic                      mclk,
    input  logic                      arst_n,
    pkword_if.dst                     pk,
    input  logic                      rpage_set,  // clear pages and pointers
    input  logic                      rpage_next, // release current read page
    input  logic                      buf_rd,
    output sens_data_pkg::mem_word_t  buf_dout,
    output sens_data_pkg::line_cnt_t  lines,      // kept lines
    output logic                      overflow    // sticky, line dropped
);

    localparam int PG_W = $clog2(sens_data_pkg::NUM_PAGES);

    sens_data_pkg::mem_word_t mem [sens_data_pkg::NUM_PAGES*sens_data_pkg::PAGE_WORDS];

    logic [PG_W-1:0]                   wpage;
    logic [PG_W-1:0]                   rpage;
    logic [PG_W:0]                     fill;       // 0..NUM_PAGES
    logic [sens_data_pkg::WADDR_W-1:0] raddr;
    logic                              room;
    logic                              keep;
    logic                              rel;

    assign room = fill < sens_data_pkg::NUM_PAGES; // otherwise wpage == rpage
    assign keep = pk.line_end && room;
    assign rel  = rpage_next && fill != 0;

    always_ff @(posedge mclk) begin
        if (pk.we && room && pk.waddr < sens_data_pkg::PAGE_WORDS) begin
            mem[{wpage, pk.waddr[sens_data_pkg::WADDR_W-1:0]}] <= pk.word;
        end
    end

    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            wpage    <= '0;
            rpage    <= '0;
            fill     <= '0;
            raddr    <= '0;
            lines    <= '0;
            overflow <= 1'b0;
            buf_dout <= '0;
        end else if (rpage_set) begin
            wpage    <= '0;
            rpage    <= '0;
            fill     <= '0;
            raddr    <= '0;
            overflow <= 1'b0;                      // line count survives
        end else begin
            if (keep) begin
                wpage <= wpage + 1'b1;
                lines <= lines + 1'b1;
            end else if (pk.line_end) begin
                overflow <= 1'b1;                  // all pages full
            end
            if (keep && !rel) begin
                fill <= fill + 1'b1;
            end else if (rel && !keep) begin
                fill <= fill - 1'b1;
            end
            if (rpage_next) begin
                rpage <= rpage + 1'b1;
                raddr <= '0;
            end else if (buf_rd) begin
                buf_dout <= mem[{rpage, raddr}];   // one cycle latency
                raddr    <= raddr + 1'b1;
            end
        end
    end

endmodule

// File: source/px_packer.sv
// pixel packer, 8 or 16 bit samples into 64-bit words, one line at a time
`timescale 1ns/100ps

module px_packer (
    input  logic                     mclk,
    input  logic                     arst_n,
    input  sens_data_pkg::pix_word_u px_data,
    input  logic                     px_valid,
    input  logic                     px_last,  // last sample of a line
    input  logic                     en,
    input  logic                     mode16,   // 4 lanes of 16, else 8 lanes of 8
    pkword_if.src                    pk
);

    sens_data_pkg::mem_word_t        acc;      // word under construction
    sens_data_pkg::mem_word_t        nxt;      // acc with current sample merged
    logic [2:0]                      lane;
    logic [sens_data_pkg::WADDR_W:0] widx;     // word index in line, saturates
    logic                            take;
    logic                            full;
    logic                            flush;

    assign take  = px_valid && en;             // disabled channel drops samples
    assign full  = mode16 ? (lane == 3'd3) : (lane == 3'd7);
    assign flush = take && (full || px_last);

    always_comb begin
        nxt = acc;
        if (mode16) begin
            nxt[lane[1:0]*sens_data_pkg::PIX_W +: sens_data_pkg::PIX_W] = px_data.raw;
        end else begin
            nxt[lane*8 +: 8] = px_data.bytes.msb; // upper byte only
        end
    end

    always_ff @(posedge mclk) begin
        if (flush) begin
            pk.word  <= nxt;                   // unfilled lanes still zero
            pk.waddr <= widx;
        end
    end

    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            acc         <= '0;
            lane        <= '0;
            widx        <= '0;
            pk.we       <= 1'b0;
            pk.line_end <= 1'b0;
        end else begin
            pk.we       <= flush;
            pk.line_end <= take && px_last;
            if (flush) begin
                acc  <= '0;
                lane <= '0;
                if (px_last) begin
                    widx <= '0;                // next line starts at word 0
                end else if (widx != '1) begin
                    widx <= widx + 1'b1;
                end
            end else if (take) begin
                acc  <= nxt;
                lane <= lane + 3'd1;
            end
        end
    end

endmodule

// File: source/cmd_deser.sv
// byte-serial command receiver, assembles 16-bit address and 32-bit data
`timescale 1ns/100ps

module cmd_deser (
    input  logic        mclk,
    input  logic        arst_n,
    input  logic [7:0]  cmd_ad,    // AL AH D0..D3 on consecutive cycles
    input  logic        cmd_stb,   // with the first byte
    output logic [15:0] cmd_addr,
    output logic [31:0] cmd_data,
    output logic        cmd_wr     // one cycle, addr/data valid
);

    logic [7:0]                         ad_r;   // input register
    logic                               stb_r;
    logic [2:0]                         cnt;    // bytes taken, 0 = idle
    logic [sens_regs_pkg::CMD_BYTES*8-1:0] sr;  // byte 0 ends up lowest

    always_ff @(posedge mclk) begin
        ad_r <= cmd_ad;
        if (stb_r || cnt != 0) begin
            sr <= {ad_r, sr[sens_regs_pkg::CMD_BYTES*8-1:8]}; // shift in from top
        end
    end

    always_ff @(posedge mclk or negedge arst_n) begin
        if (!arst_n) begin
            stb_r  <= 1'b0;
            cnt    <= '0;
            cmd_wr <= 1'b0;
        end else begin
            stb_r  <= cmd_stb;
            cmd_wr <= 1'b0;
            if (stb_r) begin
                cnt <= 3'd1;                 // restart on any new strobe
            end else if (cnt == sens_regs_pkg::CMD_BYTES - 1) begin
                cnt    <= '0;
                cmd_wr <= 1'b1;              // sixth byte lands now
            end else if (cnt != 0) begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    assign cmd_addr = sr[15:0];
    assign cmd_data = sr[sens_regs_pkg::CMD_BYTES*8-1:16];

endmodule

// File: source/pkword_if.sv
// packed word interface from pixel packer to line buffer
`timescale 1ns/100ps

interface pkword_if;

    sens_data_pkg::mem_word_t         word;     // packed pixels
    logic [sens_data_pkg::WADDR_W:0]  waddr;    // word index in line, one extra bit
    logic                             we;       // single cycle write
    logic                             line_end; // with or after last we

    modport src (
        output word, waddr, we, line_end
    );

    modport dst (
        input  word, waddr, we, line_end
    );

endinterface

// File: source/sens_data_pkg.sv
// pixel sample union, memory word and line buffer geometry
package sens_data_pkg;

    localparam int PIX_W      = 16;   // raw sample width
    localparam int WORD_W     = 64;   // memory word
    localparam int NUM_PAGES  = 4;    // pages per line buffer
    localparam int PAGE_WORDS = 32;   // one line per page
    localparam int WADDR_W    = 5;    // word address inside a page

    // one sample, seen raw or as two bytes
    typedef union packed {
        logic [PIX_W-1:0] raw;        // 16 bpp view
        struct packed {
            logic [7:0] msb;          // kept in 8 bpp mode
            logic [7:0] lsb;
        } bytes;
    } pix_word_u;

    typedef logic [WORD_W-1:0] mem_word_t;

    typedef logic [15:0] line_cnt_t;  // accepted lines, wraps

endpackage

// File: source/sens_regs_pkg.sv
// address map, command framing and status packet constants for the sensor group
package sens_regs_pkg;

    localparam int NUM_CHN           = 4;              // sensor channels
    localparam int CHN_W             = $clog2(NUM_CHN); // channel index width

    // command address map
    localparam int SENSOR_GROUP_ADDR = 'h400;          // group base, 16-bit space
    localparam int SENSOR_BASE_INC   = 'h040;          // step between channels
    localparam int MODE_RADDR        = 0;              // mode register
    localparam int STATUS_RQ_RADDR   = 1;              // status request register

    // mode register bits
    localparam int MODE_EN_BIT       = 0;              // channel enable
    localparam int MODE_16BIT_BIT    = 1;              // 1: 16 bpp, 0: 8 bpp

    localparam int CMD_BYTES         = 6;              // AL AH D0 D1 D2 D3

    // status packets
    localparam int STATUS_REG_BASE   = 'h30;           // address byte of channel 0
    localparam int STATUS_REG_INC    = 2;              // address byte step
    localparam int STATUS_BYTES      = 4;              // address byte + 3 payload

endpackage
